/* all.f */
+incdir+test
src/startscreen_pkg.sv
src/menu_state.sv
src/screen_text_rom.sv
src/draw_sequencer.sv
src/snake_startscreen.sv
test/tb_snake_startscreen.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_snake_startscreen -f all.f

# The simulator exit status is not used; the log decides.
./obj_dir/Vtb_snake_startscreen | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi

/* test/screen_model.svh */
`ifndef SCREEN_MODEL_SVH
`define SCREEN_MODEL_SVH

typedef enum logic [1:0] {
    BTN_UP,
    BTN_DOWN,
    BTN_RIGHT
} button_t;

localparam color_t BG_COLOR         = 8'hff;
localparam color_t LABEL_COLOR      = 8'h03;
localparam color_t CURSOR_ON_COLOR  = 8'h3c;
localparam color_t CURSOR_OFF_COLOR = 8'hff;
localparam color_t ROW_ON_COLOR     = 8'h03;
localparam color_t ROW_OFF_COLOR    = 8'h00;

logic       m_settings;  // On the settings page.
logic       m_main_row;
logic [1:0] m_set_row;
level_t     m_level;
draw_cmd_t  exp_q[$];    // Commands the DUT still owes.

function automatic draw_cmd_t make_cmd(draw_op_t op, int x, int y, int glyph, color_t color);
    draw_cmd_t c;
    c.op    = op;
    c.x     = x_coord_t'(x);
    c.y     = y_coord_t'(y);
    c.glyph = glyph_t'(glyph);
    c.color = color;
    return c;
endfunction

function automatic color_t underline_color(input logic row);
    return (row == m_main_row) ? CURSOR_ON_COLOR : CURSOR_OFF_COLOR;
endfunction

function automatic color_t row_color(input logic [1:0] row);
    return (row == m_set_row) ? ROW_ON_COLOR : ROW_OFF_COLOR;
endfunction

// One character every 12 pixels.
task automatic push_text(input string s, input int x0, input int y, input color_t color);
    for (int i = 0; i < s.len(); i++) begin
        exp_q.push_back(make_cmd(OP_CHAR, x0 + 12 * i, y, int'(s[i]), color));
    end
endtask

task automatic push_main_lines();
    exp_q.push_back(make_cmd(OP_LINE, 290, 362, 60, underline_color(1'b0)));
    exp_q.push_back(make_cmd(OP_LINE, 272, 387, 96, underline_color(1'b1)));
endtask

task automatic push_main_full();
    exp_q.push_back(make_cmd(OP_CLEAR, 0, 0, 0, BG_COLOR));
    push_text("START", 290, 340, LABEL_COLOR);
    push_text("SETTINGS", 272, 365, LABEL_COLOR);
    push_main_lines();
endtask

task automatic push_settings();
    exp_q.push_back(make_cmd(OP_CLEAR, 0, 0, 0, BG_COLOR));
    push_text("MODE", 48, 60, row_color(2'd0));
    push_text("LEVEL", 48, 100, row_color(2'd1));
    exp_q.push_back(make_cmd(OP_CHAR, 132, 100, 'h31 + int'(m_level), row_color(2'd1)));
    push_text("MAP", 48, 140, row_color(2'd2));
    push_text("OK", 102, 200, row_color(2'd3));
endtask

task automatic reset_model(input level_t lvl);
    m_settings = 1'b0;
    m_main_row = 1'b0;
    m_set_row  = 2'd0;
    m_level    = lvl;
    exp_q.delete();
endtask

task automatic apply_press(input button_t b, output logic start_exp);
    start_exp = 1'b0;
    if (!m_settings) begin
        if (b != BTN_RIGHT) begin
            m_main_row = !m_main_row;
            push_main_lines();
        end else if (!m_main_row) begin
            start_exp = 1'b1;  // Game start, nothing drawn.
        end else begin
            m_settings = 1'b1;
            m_set_row  = 2'd0;
            push_settings();
        end
    end else if (b == BTN_UP) begin
        m_set_row = m_set_row - 2'd1;
        push_settings();
    end else if (b == BTN_DOWN) begin
        m_set_row = m_set_row + 2'd1;
        push_settings();
    end else if (m_set_row == 2'd1) begin
        m_level = m_level + 3'd1;
        push_settings();
    end else if (m_set_row == 2'd3) begin
        m_settings = 1'b0;
        m_set_row  = 2'd0;
        push_main_full();
    end
endtask

`endif

/* test/tb_snake_startscreen.sv */
`default_nettype none

module tb_snake_startscreen;

    import startscreen_pkg::*;

    localparam level_t LEVEL_INIT     = 3'd5;  // Close to the wrap.
    localparam int     NUM_PRESSES    = 60;
    localparam int     TIMEOUT_CYCLES = NUM_PRESSES * 16 * 12 + 500;

    logic      clk;
    logic      rst;
    logic      up;
    logic      down;
    logic      right;
    logic      start;
    level_t    level;
    draw_cmd_t cmd;
    logic      cmd_req;
    logic      cmd_ack;

    logic [31:0] rng_state = 32'd35803;
    int          cycles = 0;
    int          ack_wait = 0;    // Cycles left before the next ack edge.
    logic        req_prev = 1'b0;
    draw_cmd_t   cmd_prev = '0;

    `include "screen_model.svh"

    snake_startscreen #(
        .LEVEL_INIT(LEVEL_INIT)
    ) snake_startscreen_i (
        .clk    (clk),
        .rst    (rst),
        .up     (up),
        .down   (down),
        .right  (right),
        .start  (start),
        .level  (level),
        .cmd    (cmd),
        .cmd_req(cmd_req),
        .cmd_ack(cmd_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_cmd(input string name, input draw_cmd_t got, input draw_cmd_t want);
        if (got !== want) begin
            $display("Error %s: got %h, expected %h", name, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input level_t got, input level_t want);
        if (got !== want) begin
            $display("Error level: got %h, expected %h", got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_start(input logic got, input logic want);
        if (got !== want) begin
            $display("Error start: got %h, expected %h", got, want);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int next_delay();
        return int'(next_random() % 32'd4);  // 0 to 3 cycles.
    endfunction

    function automatic button_t pick_button();
        logic [31:0] r;
        r = next_random();
        case (r[1:0])
            2'd0:    return BTN_UP;
            2'd1:    return BTN_DOWN;
            default: return BTN_RIGHT;
        endcase
    endfunction

    // Engine side of the four-phase handshake, plus protocol checks.
    task automatic serve_handshake();
        draw_cmd_t expected;
        if (!req_prev && cmd_req && cmd_ack) begin
            $display("cmd_req rose again before cmd_ack went low.");
            stop_with_failure();
        end
        if (req_prev && !cmd_req && !cmd_ack) begin
            $display("cmd_req dropped before cmd_ack was raised.");
            stop_with_failure();
        end
        if (req_prev && cmd_req) begin
            check_cmd("cmd (held during request)", cmd, cmd_prev);
        end
        if (cmd_req && !cmd_ack) begin
            if (ack_wait > 0) begin
                ack_wait--;
            end else begin
                if (exp_q.size() == 0) begin
                    $display("A command arrived while none was expected.");
                    stop_with_failure();
                end
                expected = exp_q.pop_front();
                check_cmd("cmd", cmd, expected);
                cmd_ack  = 1'b1;
                ack_wait = next_delay();
            end
        end else if (!cmd_req && cmd_ack) begin
            if (ack_wait > 0) begin
                ack_wait--;
            end else begin
                cmd_ack  = 1'b0;
                ack_wait = next_delay();
            end
        end
        req_prev = cmd_req;
        cmd_prev = cmd;
    endtask

    task automatic step_cycle();
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the press sequence did not finish.", cycles);
            stop_with_failure();
        end
        serve_handshake();
    endtask

    // Screen received, handshake idle, then three spare cycles.
    task automatic wait_screen_done();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            step_cycle();
            check_start(start, 1'b0);
            if (exp_q.size() == 0 && !cmd_req && !cmd_ack) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic press_button(input button_t b);
        logic start_exp;
        up    = (b == BTN_UP);
        down  = (b == BTN_DOWN);
        right = (b == BTN_RIGHT);
        apply_press(b, start_exp);
        step_cycle();
        up    = 1'b0;
        down  = 1'b0;
        right = 1'b0;
        check_start(start, start_exp);
        check_level(level, m_level);
        step_cycle();
        check_start(start, 1'b0);  // One-cycle pulse.
    endtask

    initial begin
        button_t b;
        rst     = 1'b1;
        up      = 1'b0;
        down    = 1'b0;
        right   = 1'b0;
        cmd_ack = 1'b0;
        reset_model(LEVEL_INIT);
        push_main_full();  // Owed right after reset.
        repeat (10) step_cycle();
        check_level(level, LEVEL_INIT);
        check_start(start, 1'b0);
        rst = 1'b0;

        for (int p = 0; p < NUM_PRESSES; p++) begin
            wait_screen_done();
            b = pick_button();
            press_button(b);
        end
        wait_screen_done();
        repeat (20) begin
            step_cycle();
            check_start(start, 1'b0);
        end
        check_level(level, m_level);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* src/snake_startscreen.sv */
`default_nettype none

module snake_startscreen #(
    parameter startscreen_pkg::level_t LEVEL_INIT = 3'd1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       up,
    input  wire logic                       down,
    input  wire logic                       right,
    output      logic                       start,
    output      startscreen_pkg::level_t    level,
    output      startscreen_pkg::draw_cmd_t cmd,
    output      logic                       cmd_req,
    input  wire logic                       cmd_ack
);

    import startscreen_pkg::*;

    menu_view_t  view;
    logic        redraw;
    screen_t     redraw_screen;
    logic        busy;
    screen_t     entry_screen;
    logic [4:0]  entry_index;
    text_entry_t entry;

    assign level = view.level;

    menu_state #(
        .LEVEL_INIT(LEVEL_INIT)
    ) menu_state_i (
        .clk          (clk),
        .rst          (rst),
        .up           (up),
        .down         (down),
        .right        (right),
        .busy         (busy),
        .view         (view),
        .redraw       (redraw),
        .redraw_screen(redraw_screen),
        .start        (start)
    );

    screen_text_rom screen_text_rom_i (
        .entry_screen(entry_screen),
        .entry_index (entry_index),
        .entry       (entry)
    );

    draw_sequencer draw_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .redraw       (redraw),
        .redraw_screen(redraw_screen),
        .view         (view),
        .entry        (entry),
        .entry_screen (entry_screen),
        .entry_index  (entry_index),
        .busy         (busy),
        .cmd          (cmd),
        .cmd_req      (cmd_req),
        .cmd_ack      (cmd_ack)
    );

endmodule

`default_nettype wire

/* src/draw_sequencer.sv */
`default_nettype none

module draw_sequencer (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         redraw,
    input  wire startscreen_pkg::screen_t     redraw_screen,
    input  wire startscreen_pkg::menu_view_t  view,
    input  wire startscreen_pkg::text_entry_t entry,
    output      startscreen_pkg::screen_t     entry_screen,
    output      logic [4:0]                   entry_index,
    output      logic                         busy,
    output      startscreen_pkg::draw_cmd_t   cmd,
    output      logic                         cmd_req,
    input  wire logic                         cmd_ack
);

    import startscreen_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,      // req high, waiting for ack high.
        ST_RELEASE   // req low, waiting for ack low.
    } seq_state_t;

    seq_state_t state;
    screen_t    scr_q;
    logic       last_q;
    logic       load;

    function automatic draw_cmd_t resolve(text_entry_t e, menu_view_t v);
        draw_cmd_t c;
        c.op    = e.op;
        c.x     = e.x;
        c.y     = e.y;
        c.glyph = e.add_level ? e.glyph + glyph_t'(v.level) : e.glyph;
        case (e.color_class)
            CLS_BACKGROUND: c.color = COLOR_BACKGROUND;
            CLS_LABEL:      c.color = COLOR_LABEL;
            CLS_MAIN_ROW0:  c.color = !v.main_row ? COLOR_CURSOR_ON : COLOR_CURSOR_OFF;
            CLS_MAIN_ROW1:  c.color = v.main_row ? COLOR_CURSOR_ON : COLOR_CURSOR_OFF;
            CLS_SET_ROW:    c.color = (e.row == v.set_row) ? COLOR_ROW_ON : COLOR_ROW_OFF;
            default:        c.color = COLOR_BACKGROUND;
        endcase
        return c;
    endfunction

    // Table is addressed with the new screen while the redraw pulse is up.
    assign entry_screen = redraw ? redraw_screen : scr_q;

    // A command word is taken on a new screen or once the previous ack has dropped.
    assign load = (state == ST_IDLE && redraw) ||
                  (state == ST_RELEASE && !cmd_ack && !last_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            busy        <= 1'b0;
            cmd_req     <= 1'b0;
            entry_index <= 5'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (redraw) begin
                        busy    <= 1'b1;
                        cmd_req <= 1'b1;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (cmd_ack) begin
                        cmd_req     <= 1'b0;
                        entry_index <= last_q ? 5'd0 : entry_index + 5'd1;
                        state       <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!cmd_ack) begin
                        if (last_q) begin
                            busy  <= 1'b0;
                            state <= ST_IDLE;
                        end else begin
                            cmd_req <= 1'b1;
                            state   <= ST_REQ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && redraw) begin
            scr_q <= redraw_screen;
        end
        if (load) begin
            cmd    <= resolve(entry, view);
            last_q <= entry.last;
        end
    end

endmodule

`default_nettype wire

/* src/screen_text_rom.sv */
`default_nettype none

module screen_text_rom (
    input  wire startscreen_pkg::screen_t     entry_screen,
    input  wire logic [4:0]                   entry_index,
    output      startscreen_pkg::text_entry_t entry
);

    import startscreen_pkg::*;

    function automatic text_entry_t mk_clear();
        text_entry_t e;
        e = '0;
        e.op          = OP_CLEAR;
        e.color_class = CLS_BACKGROUND;
        return e;
    endfunction

    function automatic text_entry_t mk_char(x_coord_t x, y_coord_t y, glyph_t g,
                                            color_class_t cls, logic [1:0] row);
        text_entry_t e;
        e = '0;
        e.op          = OP_CHAR;
        e.x           = x;
        e.y           = y;
        e.glyph       = g;
        e.color_class = cls;
        e.row         = row;
        return e;
    endfunction

    function automatic text_entry_t mk_line(x_coord_t x, y_coord_t y, glyph_t len,
                                            color_class_t cls);
        text_entry_t e;
        e = '0;
        e.op          = OP_LINE;
        e.x           = x;
        e.y           = y;
        e.glyph       = len;
        e.color_class = cls;
        return e;
    endfunction

    always_comb begin
        entry      = '0;
        entry.last = 1'b1;  // Past the end stops the walk.
        case (entry_screen)
            SCR_MAIN_FULL: begin
                case (entry_index)
                    5'd0:  entry = mk_clear();
                    5'd1:  entry = mk_char(10'd290, 9'd340, "S", CLS_LABEL, 2'd0);
                    5'd2:  entry = mk_char(10'd302, 9'd340, "T", CLS_LABEL, 2'd0);
                    5'd3:  entry = mk_char(10'd314, 9'd340, "A", CLS_LABEL, 2'd0);
                    5'd4:  entry = mk_char(10'd326, 9'd340, "R", CLS_LABEL, 2'd0);
                    5'd5:  entry = mk_char(10'd338, 9'd340, "T", CLS_LABEL, 2'd0);
                    5'd6:  entry = mk_char(10'd272, 9'd365, "S", CLS_LABEL, 2'd0);
                    5'd7:  entry = mk_char(10'd284, 9'd365, "E", CLS_LABEL, 2'd0);
                    5'd8:  entry = mk_char(10'd296, 9'd365, "T", CLS_LABEL, 2'd0);
                    5'd9:  entry = mk_char(10'd308, 9'd365, "T", CLS_LABEL, 2'd0);
                    5'd10: entry = mk_char(10'd320, 9'd365, "I", CLS_LABEL, 2'd0);
                    5'd11: entry = mk_char(10'd332, 9'd365, "N", CLS_LABEL, 2'd0);
                    5'd12: entry = mk_char(10'd344, 9'd365, "G", CLS_LABEL, 2'd0);
                    5'd13: entry = mk_char(10'd356, 9'd365, "S", CLS_LABEL, 2'd0);
                    5'd14: entry = mk_line(10'd290, 9'd362, 8'd60, CLS_MAIN_ROW0);
                    5'd15: entry = mk_line(10'd272, 9'd387, 8'd96, CLS_MAIN_ROW1);
                    default: ;
                endcase
                entry.last = entry.last | (entry_index == 5'd15);
            end
            SCR_MAIN_NAV: begin
                // Underlines only.
                case (entry_index)
                    5'd0: entry = mk_line(10'd290, 9'd362, 8'd60, CLS_MAIN_ROW0);
                    5'd1: entry = mk_line(10'd272, 9'd387, 8'd96, CLS_MAIN_ROW1);
                    default: ;
                endcase
                entry.last = entry.last | (entry_index == 5'd1);
            end
            SCR_SETTINGS: begin
                case (entry_index)
                    5'd0:  entry = mk_clear();
                    5'd1:  entry = mk_char(10'd48, 9'd60, "M", CLS_SET_ROW, 2'd0);
                    5'd2:  entry = mk_char(10'd60, 9'd60, "O", CLS_SET_ROW, 2'd0);
                    5'd3:  entry = mk_char(10'd72, 9'd60, "D", CLS_SET_ROW, 2'd0);
                    5'd4:  entry = mk_char(10'd84, 9'd60, "E", CLS_SET_ROW, 2'd0);
                    5'd5:  entry = mk_char(10'd48, 9'd100, "L", CLS_SET_ROW, 2'd1);
                    5'd6:  entry = mk_char(10'd60, 9'd100, "E", CLS_SET_ROW, 2'd1);
                    5'd7:  entry = mk_char(10'd72, 9'd100, "V", CLS_SET_ROW, 2'd1);
                    5'd8:  entry = mk_char(10'd84, 9'd100, "E", CLS_SET_ROW, 2'd1);
                    5'd9:  entry = mk_char(10'd96, 9'd100, "L", CLS_SET_ROW, 2'd1);
                    5'd10: begin
                        entry = mk_char(10'd132, 9'd100, "1", CLS_SET_ROW, 2'd1);
                        entry.add_level = 1'b1;  // Digit follows the level.
                    end
                    5'd11: entry = mk_char(10'd48, 9'd140, "M", CLS_SET_ROW, 2'd2);
                    5'd12: entry = mk_char(10'd60, 9'd140, "A", CLS_SET_ROW, 2'd2);
                    5'd13: entry = mk_char(10'd72, 9'd140, "P", CLS_SET_ROW, 2'd2);
                    5'd14: entry = mk_char(10'd102, 9'd200, "O", CLS_SET_ROW, 2'd3);
                    5'd15: entry = mk_char(10'd114, 9'd200, "K", CLS_SET_ROW, 2'd3);
                    default: ;
                endcase
                entry.last = entry.last | (entry_index == 5'd15);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/menu_state.sv */
`default_nettype none

module menu_state #(
    parameter startscreen_pkg::level_t LEVEL_INIT = 3'd1
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        up,
    input  wire logic                        down,
    input  wire logic                        right,
    input  wire logic                        busy,
    output      startscreen_pkg::menu_view_t view,
    output      logic                        redraw,
    output      startscreen_pkg::screen_t    redraw_screen,
    output      logic                        start
);

    import startscreen_pkg::*;

    logic init_q;   // First full redraw still owed.
    logic accept;

    // Buttons are dropped while a screen is in flight.
    assign accept = !busy && !redraw && !init_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            view <= '{page: PAGE_MAIN, main_row: 1'b0, set_row: 2'd0, level: LEVEL_INIT};
            init_q <= 1'b1;
            redraw <= 1'b0;
            start  <= 1'b0;
        end else begin
            init_q <= 1'b0;
            redraw <= 1'b0;
            start  <= 1'b0;
            if (init_q) begin
                redraw <= 1'b1;
            end else if (accept) begin
                case (view.page)
                    PAGE_MAIN: begin
                        if (right) begin
                            if (!view.main_row) begin
                                start <= 1'b1;
                            end else begin
                                view.page    <= PAGE_SETTINGS;
                                view.set_row <= 2'd0;
                                redraw       <= 1'b1;
                            end
                        end else if (up || down) begin
                            view.main_row <= !view.main_row;  // Two rows, so both toggle.
                            redraw        <= 1'b1;
                        end
                    end
                    default: begin
                        if (right) begin
                            if (view.set_row == 2'd1) begin
                                view.level <= view.level + 3'd1;  // Wraps 7 to 0.
                                redraw     <= 1'b1;
                            end else if (view.set_row == 2'd3) begin
                                view.page    <= PAGE_MAIN;
                                view.set_row <= 2'd0;
                                redraw       <= 1'b1;
                            end
                        end else if (up) begin
                            view.set_row <= view.set_row - 2'd1;
                            redraw       <= 1'b1;
                        end else if (down) begin
                            view.set_row <= view.set_row + 2'd1;
                            redraw       <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Screen that goes with the redraw pulse.
    always_ff @(posedge clk) begin
        if (init_q) begin
            redraw_screen <= SCR_MAIN_FULL;
        end else if (accept) begin
            case (view.page)
                PAGE_MAIN: begin
                    if (right) begin
                        redraw_screen <= SCR_SETTINGS;
                    end else begin
                        redraw_screen <= SCR_MAIN_NAV;
                    end
                end
                default: begin
                    if (right && view.set_row == 2'd3) begin
                        redraw_screen <= SCR_MAIN_FULL;
                    end else begin
                        redraw_screen <= SCR_SETTINGS;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/startscreen_pkg.sv */
`default_nettype none

package startscreen_pkg;

    typedef logic [9:0] x_coord_t;
    typedef logic [8:0] y_coord_t;
    typedef logic [7:0] glyph_t;   // ASCII code, or line length.
    typedef logic [7:0] color_t;
    typedef logic [2:0] level_t;

    // Graphics engine opcodes.
    typedef enum logic [3:0] {
        OP_CLEAR = 4'h1,
        OP_LINE  = 4'h9,
        OP_CHAR  = 4'ha
    } draw_op_t;

    // One command word per handshake, 39 bits.
    typedef struct packed {
        draw_op_t op;
        x_coord_t x;
        y_coord_t y;
        glyph_t   glyph;
        color_t   color;
    } draw_cmd_t;

    typedef enum logic [1:0] {
        SCR_MAIN_FULL = 2'd0,
        SCR_MAIN_NAV  = 2'd1,
        SCR_SETTINGS  = 2'd2
    } screen_t;

    typedef enum logic [0:0] {
        PAGE_MAIN     = 1'b0,
        PAGE_SETTINGS = 1'b1
    } page_t;

    typedef struct packed {
        page_t      page;
        logic       main_row;
        logic [1:0] set_row;
        level_t     level;
    } menu_view_t;

    typedef enum logic [2:0] {
        CLS_BACKGROUND = 3'd0,
        CLS_LABEL      = 3'd1,
        CLS_MAIN_ROW0  = 3'd2,
        CLS_MAIN_ROW1  = 3'd3,
        CLS_SET_ROW    = 3'd4  // Row taken from the entry.
    } color_class_t;

    typedef struct packed {
        draw_op_t     op;
        x_coord_t     x;
        y_coord_t     y;
        glyph_t       glyph;
        color_class_t color_class;
        logic [1:0]   row;
        logic         add_level;
        logic         last;
    } text_entry_t;

    parameter color_t COLOR_BACKGROUND = 8'hff;
    parameter color_t COLOR_LABEL      = 8'h03;
    parameter color_t COLOR_CURSOR_ON  = 8'h3c;
    parameter color_t COLOR_CURSOR_OFF = 8'hff;
    parameter color_t COLOR_ROW_ON     = 8'h03;
    parameter color_t COLOR_ROW_OFF    = 8'h00;

endpackage

`default_nettype wire
